// ==== sources.f ====
common/core_pkg.sv
common/dispatch_if.sv
common/commit_if.sv
design/instr_decode.sv
regfile/reg_rename.sv
rob/reorder_buffer.sv
design/alu_unit.sv
design/ooo_core_top.sv
dv/tb_clock.sv
dv/ooo_core_asserts.sv
dv/ooo_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator; pass only when the output holds the pass message
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module ooo_core_tb \
  -o ooo_core_sim \
  && ./obj_dir/ooo_core_sim +verilator+error+limit+1000 | tee /dev/stderr \
  | grep -q "Done: no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== dv/ooo_core_tb.sv ====
`timescale 1ns/10ps

module ooo_core_tb import core_pkg::*; ();

  localparam int N_DIRECTED = 31;
  localparam int N_RANDOM = 200;
  localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 5 * ROB_DEPTH_DEFAULT + 100;

  logic in_clk;
  logic in_rst;
  logic instr_valid;
  logic [15:0] instr;
  logic issue_ready;
  logic commit_valid;
  reg_idx_t commit_dst;
  data_t commit_value;
  logic commit_set_nzcv;
  nzcv_t commit_nzcv;

  logic [31:0] lfsr;
  int issued;
  int committed;
  int errors;

  tb_clock i_clock (
    .in_clk(in_clk),
    .in_rst(in_rst)
  );

  ooo_core_top #(.ROB_DEPTH(ROB_DEPTH_DEFAULT)) i_dut (
    .in_clk(in_clk),
    .in_rst(in_rst),
    .instr_valid(instr_valid),
    .instr(instr),
    .issue_ready(issue_ready),
    .commit_valid(commit_valid),
    .commit_dst(commit_dst),
    .commit_value(commit_value),
    .commit_set_nzcv(commit_set_nzcv),
    .commit_nzcv(commit_nzcv)
  );

  bind ooo_core_top ooo_core_asserts u_asserts (
    .in_clk(in_clk),
    .in_rst(in_rst),
    .instr_valid(instr_valid),
    .instr(instr),
    .issue_ready(issue_ready),
    .commit_valid(commit_valid),
    .commit_dst(commit_dst),
    .commit_value(commit_value),
    .commit_set_nzcv(commit_set_nzcv),
    .commit_nzcv(commit_nzcv)
  );

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      bits[i] = lfsr[0];
    end
  endtask

  function automatic logic [15:0] reg_form(input alu_op_t op, input logic flags,
                                           input reg_idx_t dst, input reg_idx_t src1,
                                           input reg_idx_t src2);
    return {1'b0, flags, op, dst, src1, src2, 3'b000};
  endfunction

  function automatic logic [15:0] imm_form(input alu_op_t op, input logic flags,
                                           input reg_idx_t dst, input reg_idx_t src1,
                                           input logic [5:0] imm);
    return {1'b1, flags, op, dst, src1, imm};
  endfunction

  // Called 1 ns after a rising edge and returns at the same point
  task automatic issue_word(input logic [15:0] w);
    while (!issue_ready) begin
      @(posedge in_clk);
      #1;
    end
    instr_valid = 1'b1;
    instr = w;
    @(posedge in_clk);
    #1;
    instr_valid = 1'b0;
    issued++;
  endtask

  task automatic wait_drain();
    while (committed != issued) begin
      @(posedge in_clk);
      #1;
    end
  endtask

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      committed <= 0;
    end else if (commit_valid) begin
      committed <= committed + 1;
    end
  end

  initial begin
    logic [15:0] w;
    logic [15:0] gap;
    instr_valid = 1'b0;
    instr = '0;
    issued = 0;
    lfsr = 32'h2f501274;
    @(negedge in_rst);
    // Idle cycles out of reset
    repeat (4) @(posedge in_clk);
    #1;

    // Two untouched registers give zero with z set
    issue_word(reg_form(ALU_ADD, 1'b1, 3'd1, 3'd2, 3'd3));
    issue_word(imm_form(ALU_ADD, 1'b0, 3'd1, 3'd0, 6'd63));
    issue_word(imm_form(ALU_ADD, 1'b1, 3'd2, 3'd1, 6'd5));
    issue_word(reg_form(ALU_SUB, 1'b1, 3'd3, 3'd2, 3'd1));
    issue_word(reg_form(ALU_ORR, 1'b0, 3'd4, 3'd3, 3'd2));
    // Borrow out of zero then a carry back to zero
    issue_word(imm_form(ALU_SUB, 1'b1, 3'd4, 3'd0, 6'd1));
    issue_word(imm_form(ALU_ADD, 1'b1, 3'd5, 3'd4, 6'd1));
    // Doubling chain up to 16'h8000 where each step reads its own destination
    issue_word(imm_form(ALU_ADD, 1'b0, 3'd6, 3'd0, 6'd1));
    for (int i = 0; i < 15; i++) begin
      issue_word(reg_form(ALU_ADD, 1'b0, 3'd6, 3'd6, 3'd6));
    end
    // Signed overflow on SUB then carry and overflow on ADD
    issue_word(reg_form(ALU_SUB, 1'b1, 3'd7, 3'd0, 3'd6));
    issue_word(reg_form(ALU_ADD, 1'b1, 3'd6, 3'd6, 3'd6));
    // Same destination written back to back
    issue_word(imm_form(ALU_ADD, 1'b0, 3'd1, 3'd0, 6'd10));
    issue_word(imm_form(ALU_ADD, 1'b0, 3'd1, 3'd0, 6'd20));
    issue_word(imm_form(ALU_ADD, 1'b0, 3'd2, 3'd1, 6'd0));
    issue_word(reg_form(ALU_AND, 1'b1, 3'd3, 3'd4, 3'd2));
    issue_word(imm_form(ALU_ORR, 1'b1, 3'd3, 3'd3, 6'd42));
    issue_word(reg_form(ALU_SUB, 1'b1, 3'd2, 3'd2, 3'd2));
    wait_drain();

    // Back-to-back burst first and idle gaps in the second half
    for (int i = 0; i < N_RANDOM; i++) begin
      take_bits(16, w);
      issue_word(w);
      if (i >= N_RANDOM / 2) begin
        take_bits(1, gap);
        if (gap[0]) begin
          @(posedge in_clk);
          #1;
        end
      end
    end
    wait_drain();
    repeat (4) @(posedge in_clk);

    errors = i_dut.u_asserts.fail_count;
    $display("errors: %0d, committed %0d of %0d issued", errors, committed, issued);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge in_clk);
    $display("watchdog expired: the core stopped committing before all instructions retired");
    $display("errors: %0d, committed %0d of %0d issued", i_dut.u_asserts.fail_count,
             committed, issued);
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== dv/ooo_core_asserts.sv ====
`timescale 1ns/10ps

module ooo_core_asserts import core_pkg::*; #(
  parameter int ROB_DEPTH = ROB_DEPTH_DEFAULT
) (
  input logic in_clk,
  input logic in_rst,
  input logic instr_valid,
  input logic [15:0] instr,
  input logic issue_ready,
  input logic commit_valid,
  input reg_idx_t commit_dst,
  input data_t commit_value,
  input logic commit_set_nzcv,
  input nzcv_t commit_nzcv
);

  // Room for every word that can be in flight with margin to spare
  localparam int FIFO_DEPTH = 2 * (ROB_DEPTH + PIPE_SLOTS);

  logic [15:0] fifo [FIFO_DEPTH];
  int wr_cnt;
  int rd_cnt;
  int pending;
  logic started;
  int fail_count;

  // Accept count two edges back, which is what the ROB has seen dispatched
  int wr_d1;
  int wr_d2;
  logic exp_ready;

  // In-order architectural model
  data_t sh_reg [REG_COUNT];
  logic [3:0] sh_nzcv;

  // Expected retirement of the oldest outstanding word
  reg_idx_t exp_dst;
  data_t exp_value;
  logic exp_set;
  logic [3:0] exp_nzcv;
  logic [3:0] exp_cmt_nzcv;

  assign pending = wr_cnt - rd_cnt;
  assign exp_ready = (ROB_DEPTH - (wr_d2 - rd_cnt)) > PIPE_SLOTS;

  initial fail_count = 0;

  always_comb begin
    logic [15:0] w;
    data_t b;
    int ua;
    int ub;
    int sa;
    int sb;
    int res_u;
    int res_s;
    logic c;
    logic v;
    w = fifo[rd_cnt % FIFO_DEPTH];
    // Bit 15 picks the zero-extended immediate as second operand
    b = w[15] ? {10'b0, w[5:0]} : sh_reg[w[5:3]];
    ua = int'(sh_reg[w[8:6]]);
    ub = int'(b);
    sa = (ua >= 32768) ? ua - 65536 : ua;
    sb = (ub >= 32768) ? ub - 65536 : ub;
    res_s = 0;
    c = 1'b0;
    v = 1'b0;
    case (w[13:12])
      2'd0: begin
        res_u = ua + ub;
        res_s = sa + sb;
        c = res_u > 65535;
      end
      2'd1: begin
        res_u = ua - ub;
        res_s = sa - sb;
        // No borrow
        c = ua >= ub;
      end
      2'd2: res_u = ua & ub;
      default: res_u = ua | ub;
    endcase
    if (w[13] == 1'b0) begin
      v = (res_s > 32767) || (res_s < -32768);
    end
    exp_dst = w[11:9];
    exp_value = res_u[15:0];
    exp_set = w[14];
    exp_nzcv = {exp_value[15], exp_value == 16'h0000, c, v};
    // Without its own flags a word carries the latest committed ones
    exp_cmt_nzcv = exp_set ? exp_nzcv : sh_nzcv;
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      wr_cnt <= 0;
      rd_cnt <= 0;
      wr_d1 <= 0;
      wr_d2 <= 0;
      started <= 1'b0;
      for (int i = 0; i < REG_COUNT; i++) begin
        sh_reg[i] <= '0;
      end
      sh_nzcv <= '0;
    end else begin
      wr_d1 <= wr_cnt;
      wr_d2 <= wr_d1;
      if (instr_valid) begin
        fifo[wr_cnt % FIFO_DEPTH] <= instr;
        wr_cnt <= wr_cnt + 1;
        started <= 1'b1;
      end
      if (commit_valid) begin
        rd_cnt <= rd_cnt + 1;
        sh_reg[exp_dst] <= exp_value;
        if (exp_set) begin
          sh_nzcv <= exp_nzcv;
        end
      end
    end
  end

  a_reset_state: assert property (@(posedge in_clk) disable iff (in_rst)
    !started |-> issue_ready && !commit_valid)
    else begin
      fail_count++;
      $error("error reset_state: not ready or a commit appeared before the first issue");
    end

  a_issue_ready: assert property (@(posedge in_clk) disable iff (in_rst)
    issue_ready == exp_ready)
    else begin
      fail_count++;
      $error("error issue_ready: expected %b, actual %b", $sampled(exp_ready),
             $sampled(issue_ready));
    end

  a_commit_order: assert property (@(posedge in_clk) disable iff (in_rst)
    commit_valid |-> pending > 0)
    else begin
      fail_count++;
      $error("error commit_order: commit with no instruction outstanding");
    end

  a_in_flight: assert property (@(posedge in_clk) disable iff (in_rst)
    pending <= ROB_DEPTH)
    else begin
      fail_count++;
      $error("error in_flight: expected at most %0d, actual %0d", ROB_DEPTH, $sampled(pending));
    end

  a_commit_dst: assert property (@(posedge in_clk) disable iff (in_rst)
    commit_valid |-> commit_dst == exp_dst)
    else begin
      fail_count++;
      $error("error commit_dst: expected %0d, actual %0d", $sampled(exp_dst),
             $sampled(commit_dst));
    end

  a_commit_value: assert property (@(posedge in_clk) disable iff (in_rst)
    commit_valid |-> commit_value == exp_value)
    else begin
      fail_count++;
      $error("error commit_value: expected %h, actual %h", $sampled(exp_value),
             $sampled(commit_value));
    end

  a_commit_set: assert property (@(posedge in_clk) disable iff (in_rst)
    commit_valid |-> commit_set_nzcv == exp_set)
    else begin
      fail_count++;
      $error("error commit_set_nzcv: expected %b, actual %b", $sampled(exp_set),
             $sampled(commit_set_nzcv));
    end

  a_commit_nzcv: assert property (@(posedge in_clk) disable iff (in_rst)
    commit_valid |-> commit_nzcv == exp_cmt_nzcv)
    else begin
      fail_count++;
      $error("error commit_nzcv: expected %b, actual %b", $sampled(exp_cmt_nzcv),
             $sampled(commit_nzcv));
    end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
  output logic in_clk,
  output logic in_rst
);

  // 8 ns period
  initial begin
    in_clk = 1'b0;
    forever #4 in_clk = ~in_clk;
  end

  // Reset held for three rising edges and released just after the third
  initial begin
    in_rst = 1'b1;
    repeat (3) @(posedge in_clk);
    #1 in_rst = 1'b0;
  end

endmodule

// ==== design/ooo_core_top.sv ====
`timescale 1ns/10ps

module ooo_core_top import core_pkg::*; #(
  parameter int ROB_DEPTH = ROB_DEPTH_DEFAULT,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input logic in_clk,
  input logic in_rst,
  input logic instr_valid,
  input logic [15:0] instr,
  output logic issue_ready,
  output logic commit_valid,
  output reg_idx_t commit_dst,
  output data_t commit_value,
  output logic commit_set_nzcv,
  output nzcv_t commit_nzcv
);

  logic dec_valid;
  alu_op_t dec_op;
  logic dec_set_nzcv;
  logic dec_use_imm;
  reg_idx_t dec_dst;
  reg_idx_t dec_src1;
  reg_idx_t dec_src2;
  data_t dec_imm;

  // ALU request and result broadcast
  logic alu_go;
  logic [TAG_W-1:0] alu_tag;
  alu_op_t alu_op;
  data_t alu_a;
  data_t alu_b;
  logic res_valid;
  logic [TAG_W-1:0] res_tag;
  data_t res_value;
  nzcv_t res_nzcv;

  dispatch_if #(.ROB_DEPTH(ROB_DEPTH)) disp_bus ();
  commit_if #(.ROB_DEPTH(ROB_DEPTH)) cmt_bus ();

  instr_decode i_decode (
    .in_clk, .in_rst, .instr_valid, .instr(instr_t'(instr)),
    .dec_valid, .dec_op, .dec_set_nzcv, .dec_use_imm,
    .dec_dst, .dec_src1, .dec_src2, .dec_imm
  );

  reg_rename #(.ROB_DEPTH(ROB_DEPTH)) i_rename (
    .in_clk, .in_rst, .dec_valid, .dec_op, .dec_set_nzcv, .dec_use_imm,
    .dec_dst, .dec_src1, .dec_src2, .dec_imm,
    .disp(disp_bus.rename), .cmt(cmt_bus.rename)
  );

  reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) i_rob (
    .in_clk, .in_rst, .disp(disp_bus.rob), .cmt(cmt_bus.rob),
    .alu_go, .alu_tag, .alu_op, .alu_a, .alu_b,
    .res_valid, .res_tag, .res_value, .res_nzcv, .issue_ready
  );

  alu_unit #(.ROB_DEPTH(ROB_DEPTH)) i_alu (
    .in_clk, .in_rst, .go(alu_go), .tag(alu_tag), .op(alu_op), .a(alu_a), .b(alu_b),
    .res_valid, .res_tag, .res_value, .res_nzcv
  );

  // Retirement to the plain commit ports
  assign commit_valid = cmt_bus.valid;
  assign commit_dst = cmt_bus.dst;
  assign commit_value = cmt_bus.value;
  assign commit_set_nzcv = cmt_bus.set_nzcv;
  assign commit_nzcv = cmt_bus.nzcv;

endmodule

// ==== design/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit import core_pkg::*; #(
  parameter int ROB_DEPTH = ROB_DEPTH_DEFAULT,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input logic in_clk,
  input logic in_rst,
  input logic go,
  input logic [TAG_W-1:0] tag,
  input alu_op_t op,
  input data_t a,
  input data_t b,
  output logic res_valid,
  output logic [TAG_W-1:0] res_tag,
  output data_t res_value,
  output nzcv_t res_nzcv
);

  logic [DATA_W:0] wide;
  logic ovf;

  always_comb begin
    ovf = 1'b0;
    case (op)
      ALU_ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        ovf = (a[DATA_W-1] == b[DATA_W-1]) && (wide[DATA_W-1] != a[DATA_W-1]);
      end
      ALU_SUB: begin
        // Carry out here means no borrow
        wide = {1'b0, a} + {1'b0, ~b} + 1'b1;
        ovf = (a[DATA_W-1] != b[DATA_W-1]) && (wide[DATA_W-1] != a[DATA_W-1]);
      end
      ALU_AND: wide = {1'b0, a & b};
      default: wide = {1'b0, a | b};
    endcase
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= go;
    end
  end

  always_ff @(posedge in_clk) begin
    if (go) begin
      res_tag <= tag;
      res_value <= wide[DATA_W-1:0];
      res_nzcv <= '{n: wide[DATA_W-1], z: (wide[DATA_W-1:0] == '0), c: wide[DATA_W], v: ovf};
    end
  end

endmodule

// ==== rob/reorder_buffer.sv ====
`timescale 1ns/10ps

module reorder_buffer import core_pkg::*; #(
  parameter int ROB_DEPTH = ROB_DEPTH_DEFAULT,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input logic in_clk,
  input logic in_rst,
  dispatch_if.rob disp,
  commit_if.rob cmt,
  output logic alu_go,
  output logic [TAG_W-1:0] alu_tag,
  output alu_op_t alu_op,
  output data_t alu_a,
  output data_t alu_b,
  input logic res_valid,
  input logic [TAG_W-1:0] res_tag,
  input data_t res_value,
  input nzcv_t res_nzcv,
  output logic issue_ready
);

  localparam int CNT_W = TAG_W + 1;

  logic [TAG_W-1:0] head;
  logic [TAG_W-1:0] tail;
  logic [CNT_W-1:0] count;

  // Entry array
  logic e_issued [ROB_DEPTH];
  logic e_done [ROB_DEPTH];
  alu_op_t e_op [ROB_DEPTH];
  logic e_set_nzcv [ROB_DEPTH];
  reg_idx_t e_dst [ROB_DEPTH];
  data_t e_result [ROB_DEPTH];
  logic e_s1_valid [ROB_DEPTH];
  data_t e_s1_value [ROB_DEPTH];
  logic [TAG_W-1:0] e_s1_tag [ROB_DEPTH];
  logic e_s2_valid [ROB_DEPTH];
  data_t e_s2_value [ROB_DEPTH];
  logic [TAG_W-1:0] e_s2_tag [ROB_DEPTH];
  logic e_f_valid [ROB_DEPTH];
  nzcv_t e_f_value [ROB_DEPTH];
  logic [TAG_W-1:0] e_f_tag [ROB_DEPTH];

  logic sel_found;
  logic [TAG_W-1:0] sel_idx;
  logic retire;

  // Incoming operands completed from the broadcast or a finished producer
  logic s1_v;
  data_t s1_d;
  logic s2_v;
  data_t s2_d;
  logic f_v;
  nzcv_t f_d;

  always_comb begin
    s1_v = disp.src1_valid;
    s1_d = disp.src1_value;
    if (!disp.src1_valid && res_valid && res_tag == disp.src1_tag) begin
      s1_v = 1'b1;
      s1_d = res_value;
    end else if (!disp.src1_valid && e_done[disp.src1_tag]) begin
      s1_v = 1'b1;
      s1_d = e_result[disp.src1_tag];
    end
    s2_v = disp.src2_valid;
    s2_d = disp.src2_value;
    if (!disp.src2_valid && res_valid && res_tag == disp.src2_tag) begin
      s2_v = 1'b1;
      s2_d = res_value;
    end else if (!disp.src2_valid && e_done[disp.src2_tag]) begin
      s2_v = 1'b1;
      s2_d = e_result[disp.src2_tag];
    end
    f_v = disp.nzcv_valid;
    f_d = disp.nzcv_value;
    if (!disp.nzcv_valid && res_valid && res_tag == disp.nzcv_tag) begin
      f_v = 1'b1;
      f_d = res_nzcv;
    end else if (!disp.nzcv_valid && e_done[disp.nzcv_tag]) begin
      f_v = 1'b1;
      f_d = e_f_value[disp.nzcv_tag];
    end
  end

  // Oldest ready entry found by scanning from the head
  always_comb begin
    int idx;
    sel_found = 1'b0;
    sel_idx = '0;
    for (int i = 0; i < ROB_DEPTH; i++) begin
      idx = (int'(head) + i) % ROB_DEPTH;
      if (!sel_found && i < int'(count) && !e_issued[idx] && e_s1_valid[idx] &&
          e_s2_valid[idx]) begin
        sel_found = 1'b1;
        sel_idx = TAG_W'(idx);
      end
    end
  end

  assign alu_go = sel_found;
  assign alu_tag = sel_idx;
  assign alu_op = e_op[sel_idx];
  assign alu_a = e_s1_value[sel_idx];
  assign alu_b = e_s2_value[sel_idx];

  assign retire = (count != '0) && e_done[head];
  assign cmt.valid = retire;
  assign cmt.tag = head;
  assign cmt.dst = e_dst[head];
  assign cmt.value = e_result[head];
  assign cmt.set_nzcv = e_set_nzcv[head];
  assign cmt.nzcv = e_f_value[head];

  assign disp.alloc_tag = tail;
  // Leave room for everything still in decode and rename
  assign issue_ready = (ROB_DEPTH - int'(count)) > PIPE_SLOTS;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        e_issued[i] <= 1'b0;
        e_done[i] <= 1'b0;
      end
    end else begin
      count <= count + CNT_W'(disp.valid) - CNT_W'(retire);
      if (retire) begin
        head <= TAG_W'((int'(head) + 1) % ROB_DEPTH);
      end
      // Operand wakeup
      if (res_valid) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
          if (!e_s1_valid[i] && e_s1_tag[i] == res_tag) begin
            e_s1_valid[i] <= 1'b1;
            e_s1_value[i] <= res_value;
          end
          if (!e_s2_valid[i] && e_s2_tag[i] == res_tag) begin
            e_s2_valid[i] <= 1'b1;
            e_s2_value[i] <= res_value;
          end
          if (!e_f_valid[i] && e_f_tag[i] == res_tag) begin
            e_f_valid[i] <= 1'b1;
            e_f_value[i] <= res_nzcv;
          end
        end
        e_done[res_tag] <= 1'b1;
        e_result[res_tag] <= res_value;
        // Own flags replace the carried ones and stop further wakeup
        if (e_set_nzcv[res_tag]) begin
          e_f_valid[res_tag] <= 1'b1;
          e_f_value[res_tag] <= res_nzcv;
        end
      end
      if (sel_found) begin
        e_issued[sel_idx] <= 1'b1;
      end
      if (disp.valid) begin
        tail <= TAG_W'((int'(tail) + 1) % ROB_DEPTH);
        e_issued[tail] <= 1'b0;
        e_done[tail] <= 1'b0;
        e_op[tail] <= disp.op;
        e_set_nzcv[tail] <= disp.set_nzcv;
        e_dst[tail] <= disp.dst;
        e_s1_valid[tail] <= s1_v;
        e_s1_value[tail] <= s1_d;
        e_s1_tag[tail] <= disp.src1_tag;
        e_s2_valid[tail] <= s2_v;
        e_s2_value[tail] <= s2_d;
        e_s2_tag[tail] <= disp.src2_tag;
        e_f_valid[tail] <= f_v;
        e_f_value[tail] <= f_d;
        e_f_tag[tail] <= disp.nzcv_tag;
      end
    end
  end

endmodule

// ==== regfile/reg_rename.sv ====
`timescale 1ns/10ps

module reg_rename import core_pkg::*; #(
  parameter int ROB_DEPTH = ROB_DEPTH_DEFAULT,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) (
  input logic in_clk,
  input logic in_rst,
  input logic dec_valid,
  input alu_op_t dec_op,
  input logic dec_set_nzcv,
  input logic dec_use_imm,
  input reg_idx_t dec_dst,
  input reg_idx_t dec_src1,
  input reg_idx_t dec_src2,
  input data_t dec_imm,
  dispatch_if.rename disp,
  commit_if.rename cmt
);

  // Architectural state with rename tags
  data_t r_value [REG_COUNT];
  logic r_valid [REG_COUNT];
  logic [TAG_W-1:0] r_tag [REG_COUNT];
  nzcv_t f_value;
  logic f_valid;
  logic [TAG_W-1:0] f_tag;

  // Decoded instruction held for the dispatch cycle
  logic d_valid;
  alu_op_t d_op;
  logic d_set_nzcv;
  logic d_use_imm;
  reg_idx_t d_dst;
  reg_idx_t d_src1;
  reg_idx_t d_src2;
  data_t d_imm;

  logic fwd1;
  logic fwd2;
  logic fwd_f;

  // A retirement this cycle still owning the source counts as ready
  assign fwd1 = cmt.valid && !r_valid[d_src1] && cmt.dst == d_src1 && cmt.tag == r_tag[d_src1];
  assign fwd2 = cmt.valid && !r_valid[d_src2] && cmt.dst == d_src2 && cmt.tag == r_tag[d_src2];
  assign fwd_f = cmt.valid && cmt.set_nzcv && !f_valid && cmt.tag == f_tag;

  assign disp.valid = d_valid;
  assign disp.op = d_op;
  assign disp.set_nzcv = d_set_nzcv;
  assign disp.dst = d_dst;

  assign disp.src1_valid = r_valid[d_src1] || fwd1;
  assign disp.src1_value = fwd1 ? cmt.value : r_value[d_src1];
  assign disp.src1_tag = r_tag[d_src1];

  // Immediate is always a ready second operand
  assign disp.src2_valid = d_use_imm || r_valid[d_src2] || fwd2;
  assign disp.src2_value = d_use_imm ? d_imm : (fwd2 ? cmt.value : r_value[d_src2]);
  assign disp.src2_tag = d_use_imm ? '0 : r_tag[d_src2];

  assign disp.nzcv_valid = f_valid || fwd_f;
  assign disp.nzcv_value = fwd_f ? cmt.nzcv : f_value;
  assign disp.nzcv_tag = f_tag;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      d_valid <= 1'b0;
      for (int i = 0; i < REG_COUNT; i++) begin
        r_value[i] <= '0;
        r_valid[i] <= 1'b1;
        r_tag[i] <= '0;
      end
      f_value <= '0;
      f_valid <= 1'b1;
      f_tag <= '0;
    end else begin
      d_valid <= dec_valid;
      if (cmt.valid) begin
        r_value[cmt.dst] <= cmt.value;
        if (cmt.tag == r_tag[cmt.dst]) begin
          r_valid[cmt.dst] <= 1'b1;
        end
        if (cmt.set_nzcv) begin
          f_value <= cmt.nzcv;
          if (cmt.tag == f_tag) begin
            f_valid <= 1'b1;
          end
        end
      end
      // Rename after commit so the newer producer wins
      if (d_valid) begin
        r_valid[d_dst] <= 1'b0;
        r_tag[d_dst] <= disp.alloc_tag;
        if (d_set_nzcv) begin
          f_valid <= 1'b0;
          f_tag <= disp.alloc_tag;
        end
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (dec_valid) begin
      d_op <= dec_op;
      d_set_nzcv <= dec_set_nzcv;
      d_use_imm <= dec_use_imm;
      d_dst <= dec_dst;
      d_src1 <= dec_src1;
      d_src2 <= dec_src2;
      d_imm <= dec_imm;
    end
  end

endmodule

// ==== design/instr_decode.sv ====
`timescale 1ns/10ps

module instr_decode import core_pkg::*; (
  input logic in_clk,
  input logic in_rst,
  input logic instr_valid,
  input instr_t instr,
  output logic dec_valid,
  output alu_op_t dec_op,
  output logic dec_set_nzcv,
  output logic dec_use_imm,
  output reg_idx_t dec_dst,
  output reg_idx_t dec_src1,
  output reg_idx_t dec_src2,
  output data_t dec_imm
);

  logic is_imm;

  // Both views agree on the opcode, so either one selects the form
  assign is_imm = instr.r_fmt.opcode[3];

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= instr_valid;
    end
  end

  always_ff @(posedge in_clk) begin
    if (instr_valid) begin
      dec_op <= alu_op_t'(instr.r_fmt.opcode[1:0]);
      dec_set_nzcv <= instr.r_fmt.opcode[2];
      dec_use_imm <= is_imm;
      dec_dst <= instr.r_fmt.dst;
      dec_src1 <= instr.r_fmt.src1;
      if (is_imm) begin
        // Zero-extended immediate form
        dec_src2 <= '0;
        dec_imm <= {{(DATA_W - 6){1'b0}}, instr.i_fmt.imm};
      end else begin
        dec_src2 <= instr.r_fmt.src2;
        dec_imm <= '0;
      end
    end
  end

endmodule

// ==== common/commit_if.sv ====
`timescale 1ns/10ps

interface commit_if import core_pkg::*; #(
  parameter int ROB_DEPTH = ROB_DEPTH_DEFAULT,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) ();

  logic valid;
  logic [TAG_W-1:0] tag;
  reg_idx_t dst;
  data_t value;
  logic set_nzcv;
  nzcv_t nzcv;

  modport rob(output valid, tag, dst, value, set_nzcv, nzcv);
  modport rename(input valid, tag, dst, value, set_nzcv, nzcv);

endinterface

// ==== common/dispatch_if.sv ====
`timescale 1ns/10ps

interface dispatch_if import core_pkg::*; #(
  parameter int ROB_DEPTH = ROB_DEPTH_DEFAULT,
  localparam int TAG_W = $clog2(ROB_DEPTH)
) ();

  logic valid;
  logic [TAG_W-1:0] alloc_tag;
  alu_op_t op;
  logic set_nzcv;
  reg_idx_t dst;

  // Each operand is either a value or the tag of its producer
  logic src1_valid;
  data_t src1_value;
  logic [TAG_W-1:0] src1_tag;
  logic src2_valid;
  data_t src2_value;
  logic [TAG_W-1:0] src2_tag;
  logic nzcv_valid;
  nzcv_t nzcv_value;
  logic [TAG_W-1:0] nzcv_tag;

  modport rename(
    output valid, op, set_nzcv, dst,
    output src1_valid, src1_value, src1_tag, src2_valid, src2_value, src2_tag,
    output nzcv_valid, nzcv_value, nzcv_tag,
    input alloc_tag
  );

  modport rob(
    input valid, op, set_nzcv, dst,
    input src1_valid, src1_value, src1_tag, src2_valid, src2_value, src2_tag,
    input nzcv_valid, nzcv_value, nzcv_tag,
    output alloc_tag
  );

endinterface

// ==== common/core_pkg.sv ====
package core_pkg;

  // Machine sizes
  localparam int DATA_W = 16;
  localparam int REG_COUNT = 8;

  // Default ROB depth for the top level and the testbench watchdog
  localparam int ROB_DEPTH_DEFAULT = 8;

  // Instructions that can sit between the issue port and the ROB
  localparam int PIPE_SLOTS = 2;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [2:0] reg_idx_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_AND = 2'd2,
    ALU_ORR = 2'd3
  } alu_op_t;

  // Opcode bit 3 picks the view, bit 2 sets flags, bits 1:0 are the ALU op
  typedef union packed {
    struct packed {
      logic [3:0] opcode;
      reg_idx_t dst;
      reg_idx_t src1;
      reg_idx_t src2;
      logic [2:0] unused;
    } r_fmt;
    struct packed {
      logic [3:0] opcode;
      reg_idx_t dst;
      reg_idx_t src1;
      logic [5:0] imm;
    } i_fmt;
  } instr_t;

endpackage
